// File: compile.f
source/adc_reg_pkg.sv
source/spi_frame_pkg.sv
source/cfg_sequencer.sv
source/spi_frame_shifter.sv
source/cal_settle_timer.sv
source/adc_spi_cfg.sv
test/adc_spi_cfg_checker.sv
test/tb_adc_spi_cfg.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_adc_spi_cfg \
	&& ./obj_dir/Vtb_adc_spi_cfg +verilator+error+limit+1000 \
		| tee /dev/stderr | grep -q "TESTS PASSED" \
	&& echo "simulation ok" \
	|| { echo "simulation reported a failure"; exit 1; }

// File: test/tb_adc_spi_cfg.sv
`timescale 1ns/1ps

module tb_adc_spi_cfg
	import adc_reg_pkg::*;
();

	// ------------------------------------------------------------
	// DUT setup
	// ------------------------------------------------------------

	localparam logic [3:0] ADC_MODE    = 4'h8;
	localparam logic       OUT_MODE    = 1'b1;
	localparam int         SETTLE      = 40;
	localparam logic [15:0] OFFSET_BASE = 16'h0100;
	localparam logic [15:0] GAIN_BASE   = 16'h0210;
	localparam logic [15:0] PHASE_BASE  = 16'h0320;
	// ctrl, sync, then select plus three trim/cal pairs per channel
	localparam int NUM_FRAMES = 2 + 7 * NUM_CHANNELS;
	// 48 sclk half periods plus launch and idle overhead per frame
	localparam int WATCH_CYCLES = NUM_FRAMES * (48 + 4) + 12 * SETTLE + 400;

	// channel 0 in the low word
	localparam trim_set_t OFFSET_SET = {OFFSET_BASE + 16'd3, OFFSET_BASE + 16'd2,
		OFFSET_BASE + 16'd1, OFFSET_BASE};
	localparam trim_set_t GAIN_SET = {GAIN_BASE + 16'd3, GAIN_BASE + 16'd2,
		GAIN_BASE + 16'd1, GAIN_BASE};
	localparam trim_set_t PHASE_SET = {PHASE_BASE + 16'd3, PHASE_BASE + 16'd2,
		PHASE_BASE + 16'd1, PHASE_BASE};

	logic clk_spi;
	logic sys_rst_n;
	logic adc_sclk;
	logic adc_mosi;
	logic adc_sen;
	logic adc_rst;
	logic adc_sync;
	logic adc_sync_dir;
	logic cfg_ready;

	// expected frames
	string       names[$];
	logic [7:0]  exp_addr[$];
	logic [15:0] exp_data[$];
	bit          exp_cal[$];

	// captured frames
	logic [23:0] shift_in;
	logic [23:0] cap[NUM_FRAMES];
	int          start_cyc[NUM_FRAMES];
	int          end_cyc[NUM_FRAMES];
	bit          ready_seen[NUM_FRAMES];
	int          frame_cnt;
	int          sen_falls;
	int          cycle;
	logic        sclk_q;
	logic        sen_q;

	int pass_cnt;
	int fail_cnt;

	adc_spi_cfg #(
		.adc_mode      (ADC_MODE),
		.out_mode      (OUT_MODE),
		.offset_trim   (OFFSET_SET),
		.gain_trim     (GAIN_SET),
		.phase_trim    (PHASE_SET),
		.SETTLE_CYCLES (SETTLE)
	) dut_i (
		.clk_spi      (clk_spi),
		.sys_rst_n    (sys_rst_n),
		.adc_sclk     (adc_sclk),
		.adc_mosi     (adc_mosi),
		.adc_sen      (adc_sen),
		.adc_rst      (adc_rst),
		.adc_sync     (adc_sync),
		.adc_sync_dir (adc_sync_dir),
		.cfg_ready    (cfg_ready)
	);

	initial
	begin
		clk_spi = 1'b0;
		forever #10 clk_spi = ~clk_spi;
	end

	// ------------------------------------------------------------
	// SPI capture on clk_spi edges
	// ------------------------------------------------------------

	initial
	begin
		shift_in  = '0;
		frame_cnt = 0;
		sen_falls = 0;
		cycle     = 0;
		sclk_q    = 1'b0;
		sen_q     = 1'b1;
	end

	always @(posedge clk_spi)
	begin
		cycle  <= cycle + 1;
		sclk_q <= adc_sclk;
		sen_q  <= adc_sen;
		// rising sclk inside the frame
		if (!adc_sen && adc_sclk && !sclk_q)
			shift_in <= {shift_in[22:0], adc_mosi};
		if (!adc_sen && sen_q)
		begin
			sen_falls <= sen_falls + 1;
			if (frame_cnt < NUM_FRAMES)
				start_cyc[frame_cnt] <= cycle;
		end
		// frame complete on rising chip select
		if (adc_sen && !sen_q && sys_rst_n)
		begin
			if (frame_cnt < NUM_FRAMES)
			begin
				cap[frame_cnt]        <= shift_in;
				end_cyc[frame_cnt]    <= cycle;
				ready_seen[frame_cnt] <= cfg_ready;
			end
			frame_cnt <= frame_cnt + 1;
		end
	end

	// ------------------------------------------------------------
	// expected table from the register rules
	// ------------------------------------------------------------

	task automatic add_entry(input string name, input logic [7:0] a,
		input logic [15:0] d, input bit cal);
		names.push_back(name);
		exp_addr.push_back(a);
		exp_data.push_back(d);
		exp_cal.push_back(cal);
	endtask

	task automatic build_table();
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			if (c == 0)
			begin
				// out_mode lands on bit 12, adc_mode on bits 3..0
				add_entry("ctrl", 8'h81, (16'(OUT_MODE) << 12) | 16'(ADC_MODE), 1'b0);
				add_entry("sync", 8'h86, 16'h000F, 1'b0);
			end
			// select is one-based
			add_entry($sformatf("ch%0d_select", c), 8'h8F, 16'(c + 1), 1'b0);
			add_entry($sformatf("ch%0d_offset", c), 8'hA0, OFFSET_BASE + 16'(c), 1'b0);
			add_entry($sformatf("ch%0d_offset_cal", c), 8'h90, 16'h0008, 1'b1);
			add_entry($sformatf("ch%0d_gain", c), 8'hA2, GAIN_BASE + 16'(c), 1'b0);
			add_entry($sformatf("ch%0d_gain_cal", c), 8'h90, 16'h0020, 1'b1);
			add_entry($sformatf("ch%0d_phase", c), 8'hA4, PHASE_BASE + 16'(c), 1'b0);
			add_entry($sformatf("ch%0d_phase_cal", c), 8'h90, 16'h0080, 1'b1);
		end
	endtask

	// one line per finished test
	task automatic log_result(input string name, input bit ok);
		if (ok)
		begin
			pass_cnt++;
			$display("pass %s", name);
		end
		else
			fail_cnt++;
	endtask

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	task automatic check_frames();
		bit          ok;
		logic [23:0] want;
		int          gap;
		for (int i = 0; i < NUM_FRAMES; i++)
		begin
			ok   = 1'b1;
			want = {exp_addr[i], exp_data[i]};
			assert (cap[i] == want) else
			begin
				$display("Fail %s expected %h actual %h", names[i], want, cap[i]);
				ok = 1'b0;
			end
			assert (!ready_seen[i]) else
			begin
				$display("cfg_ready was already high when frame %s ended", names[i]);
				ok = 1'b0;
			end
			// calibration result must settle before the next write
			if (i > 0 && exp_cal[i-1])
			begin
				gap = start_cyc[i] - end_cyc[i-1];
				assert (gap >= SETTLE) else
				begin
					$display("frame %s started only %0d cycles after a calibration",
						names[i], gap);
					ok = 1'b0;
				end
			end
			log_result(names[i], ok);
		end
	endtask

	// watchdog
	initial
	begin
		repeat (WATCH_CYCLES) @(posedge clk_spi);
		$display("the configuration sequence did not complete in %0d cycles", WATCH_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin : main_seq
		int  quiet_base;
		int  chk_fails;
		bit  ok;
		pass_cnt  = 0;
		fail_cnt  = 0;
		sys_rst_n = 1'b0;
		build_table();

		// reset held for two cycles
		repeat (2) @(posedge clk_spi);
		ok = 1'b1;
		assert ({adc_sen, adc_sclk, adc_mosi, cfg_ready, adc_rst, adc_sync, adc_sync_dir}
			== 7'b1000101) else
		begin
			$display("Fail reset_state expected %b actual %b", 7'b1000101,
				{adc_sen, adc_sclk, adc_mosi, cfg_ready, adc_rst, adc_sync, adc_sync_dir});
			ok = 1'b0;
		end
		log_result("reset_state", ok);
		sys_rst_n <= 1'b1;

		// wait for the whole sequence to finish
		@(posedge clk_spi);
		while (!cfg_ready)
			@(posedge clk_spi);
		ok = 1'b1;
		assert (frame_cnt == NUM_FRAMES) else
		begin
			$display("Fail ready_order expected %0d actual %0d", NUM_FRAMES, frame_cnt);
			ok = 1'b0;
		end
		log_result("ready_order", ok);
		check_frames();

		// no bus activity once ready
		quiet_base = sen_falls;
		repeat (100) @(posedge clk_spi);
		ok = 1'b1;
		assert (sen_falls == quiet_base && adc_sen && cfg_ready) else
		begin
			$display("SPI became active again or cfg_ready dropped after completion");
			ok = 1'b0;
		end
		log_result("ready_hold", ok);

		chk_fails = dut_i.checker_i.fail_cnt;
		$display("summary: %0d passed, %0d failed, %0d pin assertion failures",
			pass_cnt, fail_cnt, chk_fails);
		if (fail_cnt == 0 && chk_fails == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: test/adc_spi_cfg_checker.sv
`timescale 1ns/1ps

module adc_spi_cfg_checker
(
	input logic clk_spi,
	input logic sys_rst_n,
	input logic adc_sclk,
	input logic adc_mosi,
	input logic adc_sen,
	input logic cfg_ready
);

	// read by the testbench at the end
	int fail_cnt = 0;

	// ------------------------------------------------------------
	// SPI pin rules
	// ------------------------------------------------------------

	// serial clock parked while deselected
	sclk_idle_a: assert property (@(posedge clk_spi) disable iff (!sys_rst_n)
		adc_sen |-> !adc_sclk)
	else
	begin
		fail_cnt++;
		$error("adc_sclk high while adc_sen is high");
	end

	// data only moves on the falling edge
	mosi_stable_a: assert property (@(posedge clk_spi) disable iff (!sys_rst_n)
		adc_sclk |-> $stable(adc_mosi))
	else
	begin
		fail_cnt++;
		$error("adc_mosi changed while adc_sclk was high");
	end

	// ready is sticky
	ready_hold_a: assert property (@(posedge clk_spi) disable iff (!sys_rst_n)
		cfg_ready |=> cfg_ready)
	else
	begin
		fail_cnt++;
		$error("cfg_ready fell after it was set");
	end

endmodule

bind adc_spi_cfg adc_spi_cfg_checker checker_i (
	.clk_spi   (clk_spi),
	.sys_rst_n (sys_rst_n),
	.adc_sclk  (adc_sclk),
	.adc_mosi  (adc_mosi),
	.adc_sen   (adc_sen),
	.cfg_ready (cfg_ready)
);

// File: source/adc_spi_cfg.sv
`timescale 1ns/1ps

module adc_spi_cfg
	import adc_reg_pkg::*;
	import spi_frame_pkg::*;
#(
	parameter logic [3:0] adc_mode      = 4'b0000,
	parameter logic       out_mode      = 1'b0,
	parameter trim_set_t  offset_trim   = TRIM_SET_DEFAULT,
	parameter trim_set_t  gain_trim     = TRIM_SET_DEFAULT,
	parameter trim_set_t  phase_trim    = TRIM_SET_DEFAULT,
	parameter int         SETTLE_CYCLES = 512
)
(
	input  logic clk_spi,
	input  logic sys_rst_n,
	output logic adc_sclk,
	output logic adc_mosi,
	output logic adc_sen,
	output logic adc_rst,
	output logic adc_sync,
	output logic adc_sync_dir,
	output logic cfg_ready
);

	// ------------------------------------------------------------
	// board tie-offs
	// ------------------------------------------------------------

	// ADC reset is active low, keep it released
	assign adc_rst      = 1'b1;
	// level shifter for sync drives toward the ADC
	assign adc_sync_dir = 1'b1;
	assign adc_sync     = 1'b0;

	// sequencer <-> shifter
	spi_frame_u frame;
	logic       frame_start;
	logic       shifter_idle;
	// sequencer <-> timer
	logic       settle_start;
	logic       settle_done;

	// ------------------------------------------------------------
	// instances
	// ------------------------------------------------------------

	// picks the next register write
	cfg_sequencer #(
		.adc_mode    (adc_mode),
		.out_mode    (out_mode),
		.offset_trim (offset_trim),
		.gain_trim   (gain_trim),
		.phase_trim  (phase_trim)
	) sequencer_i (
		.clk_spi      (clk_spi),
		.sys_rst_n    (sys_rst_n),
		.shifter_idle (shifter_idle),
		.settle_done  (settle_done),
		.frame        (frame),
		.frame_start  (frame_start),
		.settle_start (settle_start),
		.cfg_ready    (cfg_ready)
	);

	// puts one frame on the SPI pins
	spi_frame_shifter shifter_i (
		.clk_spi      (clk_spi),
		.sys_rst_n    (sys_rst_n),
		.frame        (frame),
		.frame_start  (frame_start),
		.shifter_idle (shifter_idle),
		.adc_sclk     (adc_sclk),
		.adc_sen      (adc_sen),
		.adc_mosi     (adc_mosi)
	);

	// wait after each calibration command
	cal_settle_timer #(
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) settle_i (
		.clk_spi      (clk_spi),
		.sys_rst_n    (sys_rst_n),
		.settle_start (settle_start),
		.settle_done  (settle_done)
	);

endmodule

// File: source/cal_settle_timer.sv
`timescale 1ns/1ps

module cal_settle_timer
#(
	// at least 2
	parameter int SETTLE_CYCLES = 512
)
(
	input  logic clk_spi,
	input  logic sys_rst_n,
	input  logic settle_start,
	output logic settle_done
);

	// ------------------------------------------------------------
	// settle counter
	// ------------------------------------------------------------

	// zero means idle, counting runs 1 .. SETTLE_CYCLES-1
	localparam int CNT_W = $clog2(SETTLE_CYCLES);
	localparam logic [CNT_W-1:0] CNT_FIRST = CNT_W'(1);
	// done is registered, so it fires one count early
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SETTLE_CYCLES - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk_spi or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			cnt         <= '0;
			settle_done <= 1'b0;
		end
		else
		begin
			settle_done <= 1'b0;
			if (settle_start)
				// re-arm even if a wait is running
				cnt <= CNT_FIRST;
			else if (cnt == CNT_LAST)
			begin
				// ADC calibration result valid from here
				cnt         <= '0;
				settle_done <= 1'b1;
			end
			else if (cnt != '0)
				cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: source/spi_frame_shifter.sv
`timescale 1ns/1ps

module spi_frame_shifter
	import spi_frame_pkg::*;
(
	input  logic       clk_spi,
	input  logic       sys_rst_n,
	input  spi_frame_u frame,
	input  logic       frame_start,
	output logic       shifter_idle,
	output logic       adc_sclk,
	output logic       adc_sen,
	output logic       adc_mosi
);

	// ------------------------------------------------------------
	// half-period bookkeeping
	// ------------------------------------------------------------

	// two sclk phases per bit
	localparam int HALF_PERIODS = 2 * FRAME_BITS;
	localparam int CNT_W = $clog2(HALF_PERIODS + 1);
	// count reached after the last falling edge
	localparam logic [CNT_W-1:0] LAST_HALF = CNT_W'(HALF_PERIODS);

	logic [CNT_W-1:0]      half_cnt;
	// outgoing bits, current bit sits at the top
	logic [FRAME_BITS-1:0] shreg;

	// ------------------------------------------------------------
	// payload shift register
	// ------------------------------------------------------------

	always_ff @(posedge clk_spi)
	begin
		if (shifter_idle)
		begin
			if (frame_start)
				shreg <= frame.raw;
		end
		// advance on the falling sclk edge
		else if (half_cnt != LAST_HALF && adc_sclk)
			shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
	end

	// ------------------------------------------------------------
	// pins and busy flag
	// ------------------------------------------------------------

	always_ff @(posedge clk_spi or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			shifter_idle <= 1'b1;
			adc_sen      <= 1'b1;
			adc_sclk     <= 1'b0;
			adc_mosi     <= 1'b0;
			half_cnt     <= '0;
		end
		else if (shifter_idle)
		begin
			if (frame_start)
			begin
				// chip select low, first bit out before the first rise
				shifter_idle <= 1'b0;
				adc_sen      <= 1'b0;
				adc_mosi     <= frame.raw[FRAME_BITS-1];
				half_cnt     <= '0;
			end
		end
		else if (half_cnt == LAST_HALF)
		begin
			// one cycle after the last fall
			shifter_idle <= 1'b1;
			adc_sen      <= 1'b1;
		end
		else
		begin
			adc_sclk <= ~adc_sclk;
			half_cnt <= half_cnt + 1'b1;
			// mosi only moves as sclk goes low
			// after bit 0 the zero fill lands here
			if (adc_sclk)
				adc_mosi <= shreg[FRAME_BITS-2];
		end
	end

endmodule

// File: source/cfg_sequencer.sv
`timescale 1ns/1ps

module cfg_sequencer
	import adc_reg_pkg::*;
	import spi_frame_pkg::*;
#(
	parameter logic [3:0] adc_mode    = 4'b0000,
	parameter logic       out_mode    = 1'b0,
	parameter trim_set_t  offset_trim = TRIM_SET_DEFAULT,
	parameter trim_set_t  gain_trim   = TRIM_SET_DEFAULT,
	parameter trim_set_t  phase_trim  = TRIM_SET_DEFAULT
)
(
	input  logic       clk_spi,
	input  logic       sys_rst_n,
	input  logic       shifter_idle,
	input  logic       settle_done,
	output spi_frame_u frame,
	output logic       frame_start,
	output logic       settle_start,
	output logic       cfg_ready
);

	// ------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------

	// control flow
	localparam logic [2:0] ST_DELAY  = 3'd0;
	localparam logic [2:0] ST_LAUNCH = 3'd1;
	localparam logic [2:0] ST_WAIT   = 3'd2;
	localparam logic [2:0] ST_SETTLE = 3'd3;
	localparam logic [2:0] ST_DONE   = 3'd4;

	// which frame goes out, steps 2..8 repeat per channel
	localparam logic [3:0] STEP_CTRL     = 4'd0;
	localparam logic [3:0] STEP_SYNC     = 4'd1;
	localparam logic [3:0] STEP_SEL      = 4'd2;
	localparam logic [3:0] STEP_OFFSET   = 4'd3;
	localparam logic [3:0] STEP_OFF_CAL  = 4'd4;
	localparam logic [3:0] STEP_GAIN     = 4'd5;
	localparam logic [3:0] STEP_GAIN_CAL = 4'd6;
	localparam logic [3:0] STEP_PHASE    = 4'd7;
	localparam logic [3:0] STEP_PH_CAL   = 4'd8;

	localparam int DELAY_W = $clog2(START_DELAY + 1);
	localparam logic [DELAY_W-1:0] DELAY_LAST = DELAY_W'(START_DELAY - 1);
	localparam logic [1:0] LAST_CH = 2'(NUM_CHANNELS - 1);

	logic [2:0]         state;
	logic [3:0]         step;
	logic [1:0]         ch;
	logic [DELAY_W-1:0] delay_cnt;
	logic [3:0]         next_step;
	logic [1:0]         next_ch;
	logic               is_cal;
	logic               last_step;

	// ------------------------------------------------------------
	// step bookkeeping
	// ------------------------------------------------------------

	always_comb
	begin
		next_step = step + 4'd1;
		next_ch   = ch;
		// after the phase cal wrap back to channel select
		if (step == STEP_PH_CAL)
		begin
			next_step = STEP_SEL;
			next_ch   = ch + 2'd1;
		end
	end

	// calibration frames are followed by a settle wait
	assign is_cal = (step == STEP_OFF_CAL) || (step == STEP_GAIN_CAL) ||
		(step == STEP_PH_CAL);
	assign last_step = (step == STEP_PH_CAL) && (ch == LAST_CH);

	// ------------------------------------------------------------
	// frame contents, built through the field view
	// ------------------------------------------------------------

	always_comb
	begin
		frame.raw = '0;
		frame.fields.write = 1'b1;
		case (step)
			STEP_CTRL:
			begin
				frame.fields.addr = ADDR_CTRL;
				// out_mode at bit 12, adc_mode in the low nibble
				frame.fields.data = {3'b000, out_mode, 8'h00, adc_mode};
			end
			STEP_SYNC:
			begin
				frame.fields.addr = ADDR_SYNC;
				frame.fields.data = SYNC_WORD;
			end
			STEP_SEL:
			begin
				frame.fields.addr = ADDR_CH_SEL;
				// selector is one-based
				frame.fields.data = {14'd0, ch} + 16'd1;
			end
			STEP_OFFSET:
			begin
				frame.fields.addr = ADDR_OFFSET;
				frame.fields.data = offset_trim[ch];
			end
			STEP_GAIN:
			begin
				frame.fields.addr = ADDR_GAIN;
				frame.fields.data = gain_trim[ch];
			end
			STEP_PHASE:
			begin
				frame.fields.addr = ADDR_PHASE;
				frame.fields.data = phase_trim[ch];
			end
			STEP_OFF_CAL:
			begin
				frame.fields.addr = ADDR_CAL_CTRL;
				frame.fields.data = CAL_OFFSET;
			end
			STEP_GAIN_CAL:
			begin
				frame.fields.addr = ADDR_CAL_CTRL;
				frame.fields.data = CAL_GAIN;
			end
			default:
			begin
				frame.fields.addr = ADDR_CAL_CTRL;
				frame.fields.data = CAL_PHASE;
			end
		endcase
	end

	// ------------------------------------------------------------
	// control FSM
	// ------------------------------------------------------------

	always_ff @(posedge clk_spi or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			state        <= ST_DELAY;
			step         <= STEP_CTRL;
			ch           <= 2'd0;
			delay_cnt    <= '0;
			frame_start  <= 1'b0;
			settle_start <= 1'b0;
			cfg_ready    <= 1'b0;
		end
		else
		begin
			// both strobes are single-cycle
			frame_start  <= 1'b0;
			settle_start <= 1'b0;
			case (state)
				ST_DELAY:
				begin
					if (delay_cnt != DELAY_LAST)
						delay_cnt <= delay_cnt + 1'b1;
					else if (shifter_idle)
					begin
						// control frame is already on the frame bus
						frame_start <= 1'b1;
						state       <= ST_LAUNCH;
					end
				end
				ST_LAUNCH:
				begin
					// shifter sees the strobe now, idle drops with this edge
					state <= ST_WAIT;
				end
				ST_WAIT:
				begin
					if (shifter_idle)
					begin
						if (is_cal)
						begin
							settle_start <= 1'b1;
							state        <= ST_SETTLE;
						end
						else
						begin
							step        <= next_step;
							frame_start <= 1'b1;
							state       <= ST_LAUNCH;
						end
					end
				end
				ST_SETTLE:
				begin
					if (settle_done)
					begin
						if (last_step)
						begin
							cfg_ready <= 1'b1;
							state     <= ST_DONE;
						end
						else
						begin
							step        <= next_step;
							ch          <= next_ch;
							frame_start <= 1'b1;
							state       <= ST_LAUNCH;
						end
					end
				end
				ST_DONE:
				begin
					// parked, ready held until reset
					cfg_ready <= 1'b1;
				end
				default:
				begin
					state <= ST_DELAY;
				end
			endcase
		end
	end

endmodule

// File: source/spi_frame_pkg.sv
package spi_frame_pkg;

	import adc_reg_pkg::*;

	// one write transaction on the wire
	localparam int FRAME_BITS = 24;

	// ------------------------------------------------------------
	// frame word, two views of the same 24 bits
	// ------------------------------------------------------------

	// fields are what the sequencer fills in
	// raw is what the shifter pushes out, bit 23 first
	typedef union packed {
		logic [FRAME_BITS-1:0] raw;
		struct packed {
			// 1 = write, the link never reads
			logic      write;
			reg_addr_t addr;
			reg_word_t data;
		} fields;
	} spi_frame_u;

endpackage

// File: source/adc_reg_pkg.sv
package adc_reg_pkg;

	// ------------------------------------------------------------
	// basic register types
	// ------------------------------------------------------------

	// 7-bit register address, write flag goes above it on the wire
	typedef logic [6:0] reg_addr_t;

	// 16-bit register payload
	typedef logic [15:0] reg_word_t;

	// one trim word per ADC channel
	localparam int NUM_CHANNELS = 4;

	// index 0 is channel A
	typedef reg_word_t [NUM_CHANNELS-1:0] trim_set_t;

	// ------------------------------------------------------------
	// register map
	// ------------------------------------------------------------

	// output mode and ADC mode
	localparam reg_addr_t ADDR_CTRL     = 7'h01;
	// sync register
	localparam reg_addr_t ADDR_SYNC     = 7'h06;
	// channel selector for the trim registers below
	localparam reg_addr_t ADDR_CH_SEL   = 7'h0F;
	// calibration control, one bit per calibration kind
	localparam reg_addr_t ADDR_CAL_CTRL = 7'h10;
	// external trim registers, act on the selected channel
	localparam reg_addr_t ADDR_OFFSET   = 7'h20;
	localparam reg_addr_t ADDR_GAIN     = 7'h22;
	localparam reg_addr_t ADDR_PHASE    = 7'h24;

	// ------------------------------------------------------------
	// fixed data words
	// ------------------------------------------------------------

	// sync enable pattern
	localparam reg_word_t SYNC_WORD  = 16'h000F;

	// calibration commands for the cal control register
	localparam reg_word_t CAL_OFFSET = 16'h0008;
	localparam reg_word_t CAL_GAIN   = 16'h0020;
	localparam reg_word_t CAL_PHASE  = 16'h0080;

	// mid-scale trim, same for every channel
	localparam reg_word_t TRIM_DEFAULT = 16'h0200;
	localparam trim_set_t TRIM_SET_DEFAULT = {NUM_CHANNELS{TRIM_DEFAULT}};

	// ------------------------------------------------------------
	// sequence constants
	// ------------------------------------------------------------

	// cycles from reset release to the first frame
	localparam int START_DELAY = 5;

endpackage
